// ==== hdl/az_pkg.sv ====
/*
  shared constants and types for the voltmeter control FPGA
  every register in the SPI bank is REG_WIDTH wide, frames are FRAME_BITS long
  phase lengths are counted in system clk cycles
*/

package az_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // spi register bank

  // width of every register in the bank
  localparam int REG_WIDTH  = 24;
  // address byte plus data bits in one valid frame
  localparam int FRAME_BITS = 32;

  // 7-bit register addresses, bit 7 of the address byte is the write flag
  // anything else reads zero and ignores writes
  typedef enum logic [6:0] {
    ADDR_LED     = 7'd7,
    ADDR_SPI_MUX = 7'd8,
    ADDR_4094    = 7'd9,
    ADDR_MODE    = 7'd10,
    ADDR_MUX_HI  = 7'd11
  } reg_addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // auto-zero modulator

  // low bits of the mode register, code 3 behaves as off
  typedef enum logic [1:0] {
    MODE_OFF = 2'd0,
    MODE_SIG = 2'd1,
    MODE_AZ  = 2'd2
  } az_mode_t;

  // phase codes, also shown on the monitor pins
  typedef enum logic [1:0] {
    PH_IDLE      = 2'd0,
    PH_PRECHARGE = 2'd1,
    PH_SIGNAL    = 2'd2,
    PH_ZERO      = 2'd3
  } az_phase_t;

  // az mux select codes
  localparam logic [2:0] AZ_MUX_SIG = 3'd1;
  localparam logic [2:0] AZ_MUX_LO  = 3'd3;

  // phase lengths in clk cycles, full az period is their sum
  localparam int PC_CYCLES   = 4;
  localparam int SIG_CYCLES  = 16;
  localparam int ZERO_CYCLES = 16;

  // 4094 strobe level while spi_cs2 is inactive
  localparam logic CS2_STROBE_POL = 1'b1;

endpackage

// ==== hdl/spi_bus_if.sv ====
/*
  spi bus between the router and the register bank
  mode 0 lines only, cs is active low, no handshake
*/
`timescale 1ns/1ns

interface spi_bus_if;

  // serial clock, as seen on the pin
  logic sclk;
  // chip select for the register bank, active low
  logic cs;
  logic mosi;
  // readback from the bank, muxed onto the pin by the router
  logic miso;

  // router forwards the pins, takes miso back
  modport router (output sclk, output cs, output mosi, input miso);

  // register bank side
  modport slave (input sclk, input cs, input mosi, output miso);

endinterface

// ==== hdl/spi_regs.sv ====
/*
  spi slave and register bank, mode 0, msb first, 8-bit address then 24 data
  bus lines are sampled in the clk domain, sclk must stay at or below clk/8
  a frame is committed at cs rise only with exactly 32 bits and the write flag
  unmapped addresses read zero and ignore writes
*/
`timescale 1ns/1ns

module spi_regs (
  input  logic                         clk,
  input  logic                         arst_n,
  spi_bus_if.slave                     bus,
  output logic [az_pkg::REG_WIDTH-1:0] reg_spi_mux,
  output az_pkg::az_mode_t             mode,
  output logic                         led,
  output logic                         oe_4094,
  output logic [5:0]                   mux_hi
);
  import az_pkg::*;

  // synchronizer bits: 2 sclk, 1 cs, 0 mosi
  logic [2:0]            sync_meta;
  logic [2:0]            sync_q;
  logic                  sclk_d;
  logic                  cs_d;
  logic                  cs_act;
  logic                  sclk_rise;
  logic                  sclk_fall;
  logic                  cs_fall;
  logic                  cs_rise;
  logic [5:0]            bit_cnt;
  logic [FRAME_BITS-1:0] shift_in;
  logic [FRAME_BITS-1:0] shift_nxt;
  logic [REG_WIDTH-1:0]  shift_out;
  logic [REG_WIDTH-1:0]  rd_data;
  logic                  wr_en;
  logic [6:0]            wr_addr;
  logic [REG_WIDTH-1:0]  reg_led;
  logic [REG_WIDTH-1:0]  reg_4094;
  logic [REG_WIDTH-1:0]  reg_mode;
  logic [REG_WIDTH-1:0]  reg_mux_hi;

  ////////////////////////////////////////////////////////////////////////////
  // two-flop sync and edge detect

  // cs resets high so no frame starts out of reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_meta <= 3'b010;
      sync_q    <= 3'b010;
      sclk_d    <= 1'b0;
      cs_d      <= 1'b1;
    end else begin
      sync_meta <= {bus.sclk, bus.cs, bus.mosi};
      sync_q    <= sync_meta;
      sclk_d    <= sync_q[2];
      cs_d      <= sync_q[1];
    end
  end

  assign cs_act    = ~sync_q[1];
  // sclk edges only count inside a frame
  assign sclk_rise = cs_act & sync_q[2] & ~sclk_d;
  assign sclk_fall = cs_act & ~sync_q[2] & sclk_d;
  assign cs_fall   = ~sync_q[1] & cs_d;
  assign cs_rise   = sync_q[1] & ~cs_d;

  // shift register contents after the current mosi bit
  assign shift_nxt = {shift_in[FRAME_BITS-2:0], sync_q[0]};

  ////////////////////////////////////////////////////////////////////////////
  // frame receive

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt  <= '0;
      shift_in <= '0;
    end else if (cs_fall) begin
      bit_cnt <= '0;
    end else if (sclk_rise) begin
      shift_in <= shift_nxt;
      // saturate so long frames never wrap back to 32
      if (bit_cnt != 6'h3f) begin
        bit_cnt <= bit_cnt + 6'd1;
      end
    end
  end

  // commit only a full frame with the write flag set
  assign wr_en   = cs_rise && (bit_cnt == 6'(FRAME_BITS)) && shift_in[FRAME_BITS-1];
  assign wr_addr = shift_in[FRAME_BITS-2 -: 7];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_led     <= '0;
      reg_spi_mux <= '0;
      reg_4094    <= '0;
      reg_mode    <= '0;
      reg_mux_hi  <= '0;
    end else if (wr_en) begin
      case (reg_addr_t'(wr_addr))
        ADDR_LED:     reg_led     <= shift_in[REG_WIDTH-1:0];
        ADDR_SPI_MUX: reg_spi_mux <= shift_in[REG_WIDTH-1:0];
        ADDR_4094:    reg_4094    <= shift_in[REG_WIDTH-1:0];
        ADDR_MODE:    reg_mode    <= shift_in[REG_WIDTH-1:0];
        ADDR_MUX_HI:  reg_mux_hi  <= shift_in[REG_WIDTH-1:0];
        default:      ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // readback

  // address comes from the byte as it completes on the 8th rise
  always_comb begin
    case (reg_addr_t'(shift_nxt[6:0]))
      ADDR_LED:     rd_data = reg_led;
      ADDR_SPI_MUX: rd_data = reg_spi_mux;
      ADDR_4094:    rd_data = reg_4094;
      ADDR_MODE:    rd_data = reg_mode;
      ADDR_MUX_HI:  rd_data = reg_mux_hi;
      default:      rd_data = '0;
    endcase
  end

  // load at the 8th rise, msb sits on miso before the 9th rise
  // then shift on each fall after a data bit was taken
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      shift_out <= '0;
    end else if (cs_fall) begin
      shift_out <= '0;
    end else if (sclk_rise && bit_cnt == 6'd7) begin
      shift_out <= rd_data;
    end else if (sclk_fall && bit_cnt > 6'd8) begin
      shift_out <= {shift_out[REG_WIDTH-2:0], 1'b0};
    end
  end

  assign bus.miso = shift_out[REG_WIDTH-1];

  // register fields out to the pins and the modulator
  assign led     = reg_led[0];
  assign oe_4094 = reg_4094[0];
  assign mux_hi  = reg_mux_hi[5:0];
  assign mode    = az_mode_t'(reg_mode[1:0]);

endmodule

// ==== hdl/spi_mux.sv ====
/*
  spi router, purely combinational pin to pin
  spi_cs addresses the register bank, spi_cs2 the 4094 chain when routed
  4094 clock and data stay low unless the route is enabled and cs2 is low
*/
`timescale 1ns/1ns

module spi_mux (
  input  logic      spi_clk,
  input  logic      spi_cs,
  input  logic      spi_cs2,
  input  logic      spi_mosi,
  output logic      spi_miso,
  spi_bus_if.router bus,
  input  logic      route_4094,
  output logic      glb_4094_clk,
  output logic      glb_4094_data,
  output logic      glb_4094_strobe,
  input  logic      u1004_4094_data
);
  import az_pkg::*;

  logic route_act;

  ////////////////////////////////////////////////////////////////////////////
  // register bank side

  // bank always sees the pins, it only reacts to its own cs
  assign bus.sclk = spi_clk;
  assign bus.cs   = spi_cs;
  assign bus.mosi = spi_mosi;

  ////////////////////////////////////////////////////////////////////////////
  // 4094 chain side

  // routed frame in progress
  assign route_act = route_4094 & ~spi_cs2;

  // clock and data gated, held low when idle
  assign glb_4094_clk  = route_act & spi_clk;
  assign glb_4094_data = route_act & spi_mosi;

  // strobe follows cs2 at the configured polarity
  // route disabled parks it at the inactive level
  always_comb begin
    if (route_4094) begin
      glb_4094_strobe = spi_cs2 ~^ CS2_STROBE_POL;
    end else begin
      glb_4094_strobe = ~CS2_STROBE_POL;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // miso select

  // bank readback wins while spi_cs is low
  always_comb begin
    if (!spi_cs) begin
      spi_miso = bus.miso;
    end else if (route_act) begin
      // 4094 chain tail data back to the mcu
      spi_miso = u1004_4094_data;
    end else begin
      spi_miso = 1'b0;
    end
  end

endmodule

// ==== hdl/modulation_az.sv ====
/*
  auto-zero phase sequencer, clocked by the system clk
  reacts one cycle after a mode change, az period is 36 cycles
  precharge switch is on only during precharge, mux held at the lo input then
*/
`timescale 1ns/1ns

module modulation_az (
  input  logic             clk,
  input  logic             arst_n,
  input  az_pkg::az_mode_t mode,
  output logic [2:0]       mux_az,
  output logic             sw_pc_ctl,
  output logic [6:0]       vec_monitor
);
  import az_pkg::*;

  az_phase_t  phase;
  az_mode_t   mode_d;
  logic [4:0] cnt;
  logic       cycle_tgl;
  logic       mode_chg;
  logic       last;
  logic       cycle_start;

  ////////////////////////////////////////////////////////////////////////////
  // phase timing

  // previous mode, a difference restarts the sequence
  assign mode_chg = (mode != mode_d);

  // final cycle of the current timed phase
  always_comb begin
    case (phase)
      PH_PRECHARGE: last = (cnt == 5'(PC_CYCLES - 1));
      PH_SIGNAL:    last = (cnt == 5'(SIG_CYCLES - 1));
      PH_ZERO:      last = (cnt == 5'(ZERO_CYCLES - 1));
      default:      last = 1'b1;
    endcase
  end

  // new az cycle: entering az, leaving idle, or end of zero phase
  assign cycle_start = (mode == MODE_AZ) &&
                       (mode_chg || phase == PH_IDLE || (phase == PH_ZERO && last));

  ////////////////////////////////////////////////////////////////////////////
  // phase fsm

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase     <= PH_IDLE;
      mode_d    <= MODE_OFF;
      cnt       <= '0;
      cycle_tgl <= 1'b0;
    end else begin
      mode_d <= mode;
      case (mode)
        MODE_SIG: begin
          // fixed signal input
          phase <= PH_SIGNAL;
          cnt   <= '0;
        end
        MODE_AZ: begin
          if (cycle_start) begin
            phase     <= PH_PRECHARGE;
            cnt       <= '0;
            cycle_tgl <= ~cycle_tgl;
          end else if (!last) begin
            cnt <= cnt + 5'd1;
          end else begin
            cnt <= '0;
            // zero wraps through cycle_start above
            case (phase)
              PH_PRECHARGE: phase <= PH_SIGNAL;
              default:      phase <= PH_ZERO;
            endcase
          end
        end
        default: begin
          // off, and the unused code 3
          phase <= PH_IDLE;
          cnt   <= '0;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // outputs

  // only the signal phase selects the input, all else sits at lo
  always_comb begin
    case (phase)
      PH_SIGNAL: mux_az = AZ_MUX_SIG;
      default:   mux_az = AZ_MUX_LO;
    endcase
  end

  assign sw_pc_ctl = (phase == PH_PRECHARGE);

  // monitor: phase, precharge, cycle toggle, upper bits spare
  assign vec_monitor = {3'b000, cycle_tgl, sw_pc_ctl, phase};

endmodule

// ==== hdl/top.sv ====
/*
  voltmeter front end control FPGA top level
  spi_clk must stay at or below clk/8, the spi lines are sampled on clk
  after reset all registers are zero, the az mode is off
*/
`timescale 1ns/1ns

module top (
  input  logic       clk,
  input  logic       arst_n,
  // spi from the mcu
  input  logic       spi_clk,
  input  logic       spi_cs,
  input  logic       spi_cs2,
  input  logic       spi_mosi,
  output logic       spi_miso,
  // 4094 chain tail
  input  logic       u1004_4094_data,
  output logic       led0,
  // 4094 chain
  output logic       glb_4094_clk,
  output logic       glb_4094_data,
  output logic       glb_4094_strobe_ctl,
  output logic       oe_4094_ctl,
  // analog switches and muxes
  output logic       sig_pc_sw_ctl,
  output logic [2:0] u413_a_ctl,
  output logic [2:0] u402_a_ctl,
  output logic [2:0] u414_a_ctl,
  // scope monitor pins
  output logic [6:0] mon
);
  import az_pkg::*;

  logic [REG_WIDTH-1:0] reg_spi_mux;
  az_mode_t             mode;

  ////////////////////////////////////////////////////////////////////////////
  // spi routing

  spi_bus_if spi_bus ();

  spi_mux spi_mux0 (
    .spi_clk         (spi_clk),
    .spi_cs          (spi_cs),
    .spi_cs2         (spi_cs2),
    .spi_mosi        (spi_mosi),
    .spi_miso        (spi_miso),
    .bus             (spi_bus.router),
    // bit 0 of the spi mux register enables the 4094 route
    .route_4094      (reg_spi_mux[0]),
    .glb_4094_clk    (glb_4094_clk),
    .glb_4094_data   (glb_4094_data),
    .glb_4094_strobe (glb_4094_strobe_ctl),
    .u1004_4094_data (u1004_4094_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // register bank

  // high-side mux: low three bits u413, upper three u402
  spi_regs spi_regs0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .bus         (spi_bus.slave),
    .reg_spi_mux (reg_spi_mux),
    .mode        (mode),
    .led         (led0),
    .oe_4094     (oe_4094_ctl),
    .mux_hi      ({u402_a_ctl, u413_a_ctl})
  );

  ////////////////////////////////////////////////////////////////////////////
  // auto-zero modulator

  modulation_az modulation_az0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .mode        (mode),
    .mux_az      (u414_a_ctl),
    .sw_pc_ctl   (sig_pc_sw_ctl),
    .vec_monitor (mon)
  );

endmodule

// ==== sim/top_chk.sv ====
/*
  assertions bound into top, sampled on the rising clk edge
  all checks are off while arst_n is low
*/
`timescale 1ns/1ns

module top_chk (
  input logic       clk,
  input logic       arst_n,
  input logic       spi_cs,
  input logic       spi_cs2,
  input logic       spi_miso,
  input logic       route_4094,
  input logic       glb_4094_clk,
  input logic       sig_pc_sw_ctl,
  input logic [2:0] u414_a_ctl
);
  import az_pkg::*;

  // number of assertion failures so far
  int fail_cnt = 0;

  // az mux sits at lo whenever the precharge switch is closed
  a_pc_mux: assert property (@(posedge clk) disable iff (!arst_n)
    sig_pc_sw_ctl |-> (u414_a_ctl == AZ_MUX_LO))
    else begin
      $error("precharge switch on with az mux not at lo");
      fail_cnt++;
    end

  // no 4094 clock unless a routed cs2 frame is open
  a_4094_idle: assert property (@(posedge clk) disable iff (!arst_n)
    !(route_4094 && !spi_cs2) |-> !glb_4094_clk)
    else begin
      $error("4094 clock active while the route is idle");
      fail_cnt++;
    end

  // miso released when neither chip select is active
  a_miso_idle: assert property (@(posedge clk) disable iff (!arst_n)
    (spi_cs && spi_cs2) |-> !spi_miso)
    else begin
      $error("miso driven with both chip selects high");
      fail_cnt++;
    end

endmodule

bind top top_chk chk0 (
  .clk           (clk),
  .arst_n        (arst_n),
  .spi_cs        (spi_cs),
  .spi_cs2       (spi_cs2),
  .spi_miso      (spi_miso),
  .route_4094    (reg_spi_mux[0]),
  .glb_4094_clk  (glb_4094_clk),
  .sig_pc_sw_ctl (sig_pc_sw_ctl),
  .u414_a_ctl    (u414_a_ctl)
);

// ==== sim/tb_top.sv ====
/*
  directed testbench for the voltmeter control FPGA top level
  spi is bit-banged at clk/16, inputs change 1 ns after the rising clk edge
  random data comes from an lfsr with a fixed seed, so every run is the same
*/
`timescale 1ns/1ns

module tb_top;
  import az_pkg::*;

  localparam int NUM_TESTS = 6;
  // sclk half period in clk cycles
  localparam int HALF_SCLK = 8;

  logic        clk = 1'b0;
  logic        arst_n, spi_clk, spi_cs, spi_cs2, spi_mosi, u1004_4094_data;
  logic        spi_miso, led0, oe_4094_ctl, sig_pc_sw_ctl;
  logic        glb_4094_clk, glb_4094_data, glb_4094_strobe_ctl;
  logic [2:0]  u413_a_ctl, u402_a_ctl, u414_a_ctl;
  logic [6:0]  mon;
  logic [31:0] lfsr_state = 32'h26da_1b3c;
  string       cur_test;
  int          test_errs;
  int          tests_passed = 0;
  int          tests_failed = 0;

  // 8 ns clock
  always #4 clk = ~clk;

  top dut0 (.*);

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken, newest bit lands in bit 0
  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  // returns 1 ns after the n-th rising edge
  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] exp, act);
    $display("Fail %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
    test_errs++;
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      tests_passed++;
      $display("%s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", cur_test, test_errs);
    end
  endtask

  // mode 0 frame under spi_cs, bits are {write, addr, data} msb first
  // bits past 32 are zero, rd collects miso over the 24 data bits
  task automatic spi_frame(input logic [6:0] addr, input logic wr, input logic [23:0] data,
                           input int nbits, output logic [23:0] rd);
    logic [63:0] bits;
    bits = {wr, addr, data, 32'h0};
    rd = '0;
    spi_cs = 1'b0;
    wait_clks(HALF_SCLK);
    for (int i = 0; i < nbits; i++) begin
      spi_mosi = bits[63-i];
      wait_clks(HALF_SCLK);
      // master takes miso at the rising sclk
      if (i >= 8) rd = {rd[22:0], spi_miso};
      spi_clk = 1'b1;
      wait_clks(HALF_SCLK);
      spi_clk = 1'b0;
    end
    wait_clks(HALF_SCLK);
    spi_cs = 1'b1;
    wait_clks(HALF_SCLK);
  endtask

  // az pins right now, read as a phase code
  function automatic logic [1:0] pin_phase();
    if (sig_pc_sw_ctl) return PH_PRECHARGE;
    else if (u414_a_ctl == AZ_MUX_SIG) return PH_SIGNAL;
    else return PH_ZERO;
  endfunction

  // length of the phase present now, mon must show it on every cycle
  task automatic phase_run(output logic [1:0] ph, output int len, output logic tgl);
    logic [6:0] exp;
    ph  = pin_phase();
    tgl = mon[3];
    len = 0;
    exp = {3'b000, tgl, ph == PH_PRECHARGE, ph};
    while (pin_phase() == ph && len < 100) begin
      if (mon !== exp) report_mismatch("mon", exp, mon);
      len++;
      wait_clks(1);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests

  task automatic test_reset();
    logic [13:0] exp;
    logic [13:0] act;
    begin_test("reset");
    // led, oe, high-side mux, precharge, az mux, strobe, miso
    exp = {1'b0, 1'b0, 6'd0, 1'b0, AZ_MUX_LO, ~CS2_STROBE_POL, 1'b0};
    act = {led0, oe_4094_ctl, u402_a_ctl, u413_a_ctl, sig_pc_sw_ctl, u414_a_ctl,
           glb_4094_strobe_ctl, spi_miso};
    if (act !== exp) report_mismatch("pins", exp, act);
    end_test();
  endtask

  task automatic test_reg_rw();
    logic [6:0]  addrs [6];
    logic [23:0] vals [6];
    logic [31:0] r;
    logic [23:0] rd;
    logic [23:0] exp;
    // address 12 is unmapped
    addrs = '{ADDR_LED, ADDR_SPI_MUX, ADDR_4094, ADDR_MODE, ADDR_MUX_HI, 7'd12};
    begin_test("reg_rw");
    foreach (addrs[i]) begin
      take_bits(24, r);
      vals[i] = r[23:0];
      spi_frame(addrs[i], 1'b1, vals[i], 32, rd);
    end
    wait_clks(8);
    foreach (addrs[i]) begin
      spi_frame(addrs[i], 1'b0, 24'h0, 32, rd);
      exp = (i == 5) ? 24'h0 : vals[i];
      if (rd !== exp) report_mismatch($sformatf("addr %0d", addrs[i]), exp, rd);
    end
    // led, oe and high-side mux follow the low bits
    if ({led0, oe_4094_ctl, u402_a_ctl, u413_a_ctl} !== {vals[0][0], vals[2][0], vals[4][5:0]})
      report_mismatch("pins", {vals[0][0], vals[2][0], vals[4][5:0]},
                      {led0, oe_4094_ctl, u402_a_ctl, u413_a_ctl});
    end_test();
  endtask

  task automatic test_short_frames();
    int          lens [2];
    logic [31:0] r;
    logic [23:0] v;
    logic [23:0] rd;
    lens = '{31, 33};
    begin_test("short_frames");
    take_bits(24, r);
    v = r[23:0];
    spi_frame(ADDR_LED, 1'b1, v, 32, rd);
    foreach (lens[k]) begin
      spi_frame(ADDR_LED, 1'b1, ~v, lens[k], rd);
      spi_frame(ADDR_LED, 1'b0, 24'h0, 32, rd);
      if (rd !== v) report_mismatch($sformatf("%0d-bit frame", lens[k]), v, rd);
    end
    if (led0 !== v[0]) report_mismatch("led0", v[0], led0);
    end_test();
  endtask

  task automatic test_routing();
    logic [31:0] r;
    logic [23:0] rd;
    logic [7:0]  pat;
    logic [3:0]  exp;
    begin_test("routing");
    take_bits(8, r);
    pat = r[7:0];
    // first pass routed, second pass route disabled
    for (int routed = 1; routed >= 0; routed--) begin
      spi_frame(ADDR_SPI_MUX, 1'b1, 24'(routed), 32, rd);
      spi_cs2 = 1'b0;
      for (int i = 7; i >= 0; i--) begin
        take_bits(1, r);
        spi_mosi = pat[i];
        u1004_4094_data = r[0];
        wait_clks(HALF_SCLK);
        spi_clk = 1'b1;
        #1;
        // clk, data, strobe and miso at the 4094 clock edge
        exp = {routed[0], routed[0] & pat[i], ~CS2_STROBE_POL, routed[0] & r[0]};
        if ({glb_4094_clk, glb_4094_data, glb_4094_strobe_ctl, spi_miso} !== exp)
          report_mismatch($sformatf("bit %0d route %0d", i, routed), exp,
                          {glb_4094_clk, glb_4094_data, glb_4094_strobe_ctl, spi_miso});
        wait_clks(HALF_SCLK);
        spi_clk = 1'b0;
      end
      wait_clks(HALF_SCLK);
      spi_cs2 = 1'b1;
      wait_clks(1);
      exp = routed ? CS2_STROBE_POL : ~CS2_STROBE_POL;
      if (glb_4094_strobe_ctl !== exp[0])
        report_mismatch("strobe after cs2", exp[0], glb_4094_strobe_ctl);
    end
    end_test();
  endtask

  task automatic test_az_cycle();
    logic [23:0] rd;
    logic [1:0]  ph [4];
    int          len [4];
    logic        tgl [4];
    logic [1:0]  exp_ph [4];
    int          exp_len [4];
    int          n;
    exp_ph  = '{PH_PRECHARGE, PH_SIGNAL, PH_ZERO, PH_PRECHARGE};
    exp_len = '{PC_CYCLES, SIG_CYCLES, ZERO_CYCLES, PC_CYCLES};
    begin_test("az_cycle");
    spi_frame(ADDR_MODE, 1'b1, 24'(MODE_AZ), 32, rd);
    // align to the first cycle of a precharge pulse
    for (n = 0; n < 100 && sig_pc_sw_ctl; n++) wait_clks(1);
    for (n = 0; n < 100 && !sig_pc_sw_ctl; n++) wait_clks(1);
    if (!sig_pc_sw_ctl) begin
      $display("%s: no precharge pulse within 100 cycles of the mode write", cur_test);
      test_errs++;
    end
    for (int i = 0; i < 4; i++) begin
      phase_run(ph[i], len[i], tgl[i]);
      if (ph[i] !== exp_ph[i]) report_mismatch($sformatf("phase %0d", i), exp_ph[i], ph[i]);
      if (len[i] != exp_len[i]) report_mismatch($sformatf("length %0d", i), exp_len[i], len[i]);
    end
    if (len[0] + len[1] + len[2] != 36) report_mismatch("period", 36, len[0] + len[1] + len[2]);
    // toggle bit flips once per az cycle
    if (tgl[3] === tgl[0]) report_mismatch("cycle toggle", !tgl[0], tgl[3]);
    end_test();
  endtask

  task automatic test_fixed_modes();
    logic [23:0] rd;
    az_mode_t    modes [2];
    logic [2:0]  exp_mux [2];
    logic [2:0]  bad_mux;
    int          pulses;
    modes   = '{MODE_SIG, MODE_OFF};
    exp_mux = '{AZ_MUX_SIG, AZ_MUX_LO};
    begin_test("fixed_modes");
    foreach (modes[k]) begin
      spi_frame(ADDR_MODE, 1'b1, 24'(modes[k]), 32, rd);
      bad_mux = exp_mux[k];
      pulses = 0;
      repeat (100) begin
        if (u414_a_ctl !== exp_mux[k]) bad_mux = u414_a_ctl;
        if (sig_pc_sw_ctl) pulses++;
        wait_clks(1);
      end
      if (bad_mux !== exp_mux[k]) report_mismatch($sformatf("u414 mode %0d", k), exp_mux[k], bad_mux);
      if (pulses != 0) report_mismatch("precharge cycles", 0, pulses);
    end
    end_test();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // run

  initial begin
    arst_n = 1'b0;
    spi_clk = 1'b0;
    spi_cs = 1'b1;
    spi_cs2 = 1'b1;
    spi_mosi = 1'b0;
    u1004_4094_data = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;
    wait_clks(2);
    test_reset();
    test_reg_rw();
    test_short_frames();
    test_routing();
    test_az_cycle();
    test_fixed_modes();
    $display("tests passed %0d, failed %0d, assertion failures %0d",
             tests_passed, tests_failed, dut0.chk0.fail_cnt);
    if (tests_failed == 0 && dut0.chk0.fail_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // 20 us per test
  initial begin
    #(NUM_TESTS * 20_000);
    $display("watchdog expired before the tests finished");
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== verilog.f ====
hdl/az_pkg.sv
hdl/spi_bus_if.sv
hdl/spi_regs.sv
hdl/spi_mux.sv
hdl/modulation_az.sv
hdl/top.sv
sim/top_chk.sv
sim/tb_top.sv
